/* sim/sprite_table_input.txt */
# columns: written n_reg select_field data check success_next read_data
# all hex, data bits 31 to 27 are overwritten with random bits by the testbench
0 00 0 00000000 00000 0 001
0 00 0 00000000 00000 0 001
0 05 0 00000000 0c832 0 001
0 1f 3 07ffffff 3ffff 0 001
1 05 2 01900000 00000 1 001
1 05 1 00006400 0c832 1 001
1 05 0 000000a5 0c832 1 001
0 00 0 00000000 0c832 0 0a5
0 00 0 00000000 0c832 0 0a5
0 00 0 00000000 0c833 0 001
0 00 0 00000000 0ca32 0 001
1 05 0 00000123 0c832 1 001
0 00 0 00000000 0c832 0 123
1 05 1 00006600 0c832 1 001
0 00 0 00000000 0c832 0 001
0 00 0 00000000 0c833 0 123
1 05 2 03200000 0c833 1 001
0 00 0 00000000 0c833 0 001
0 00 0 00000000 19033 0 123
1 05 0 07fffea5 19033 1 001
0 00 0 00000000 19033 0 0a5
0 00 0 00000000 3ffff 0 001
1 00 2 03200000 19033 0 001
1 00 1 00006600 19033 0 001
1 00 0 00000055 19033 0 001
0 00 0 00000000 19033 0 0a5
1 00 0 00000077 00000 0 001
0 00 0 00000000 00000 0 001
1 05 3 07ffffff 19033 0 001
0 00 0 00000000 19033 0 0a5
0 00 0 00000000 3ffff 0 001
1 07 3 07ffffff 00000 0 001
1 07 3 00000000 00000 0 001
0 00 0 00000000 00000 0 001
0 00 0 00000000 3ffff 0 001
1 05 0 000000a6 19033 1 001
1 00 0 000000a6 19033 0 001
1 05 0 000000a7 19033 1 001
1 05 3 000000a8 19033 0 001
0 00 0 00000000 19033 0 0a7
1 09 2 00400000 02020 1 001
1 09 1 00004000 02020 1 001
1 09 0 00000099 02020 1 001
0 00 0 00000000 02020 0 099
1 03 2 00400000 02020 1 001
1 03 1 00004000 02020 1 001
1 03 0 00000033 02020 1 001
0 00 0 00000000 02020 0 033
0 00 0 00000000 02020 0 033
0 00 0 00000000 19033 0 0a7
1 03 2 00440000 02020 1 001
0 00 0 00000000 02020 0 099
0 00 0 00000000 02220 0 033
1 11 0 00000117 02020 1 001
1 11 1 00004000 02020 1 001
1 11 2 00400000 02020 1 001
0 00 0 00000000 02020 0 099
1 09 1 00004200 02020 1 001
0 00 0 00000000 02020 0 117
0 00 0 00000000 02021 0 099
1 03 2 00400000 02020 1 001
0 00 0 00000000 02020 0 033
1 00 0 00000000 02020 0 001
1 05 3 00000000 19033 0 001
0 00 0 00000000 02020 0 033
1 1f 3 00000000 02020 0 001
0 00 0 00000000 19033 0 0a7
1 09 0 00000199 02021 1 001
0 00 0 00000000 02021 0 199
1 05 0 000000a7 19033 1 001
0 00 0 00000000 19033 0 0a7
0 00 0 00000000 19034 0 001
0 00 0 00000000 19233 0 001
0 00 0 00000000 02022 0 001
0 00 0 00000000 02420 0 001
0 00 0 00000000 066c8 0 001
0 00 0 00000000 000a7 0 001
0 00 0 00000000 00000 0 001
0 00 0 00000000 3ffff 0 001
1 1f 1 0003fe00 3ffff 1 001
1 1f 2 07fc0000 3ffff 1 001
1 1f 0 000001fe 3ffff 1 001
0 00 0 00000000 3ffff 0 1fe
1 1e 2 07fc0000 3ffff 1 001
1 1e 1 0003fe00 3ffff 1 001
1 1e 0 00000000 3ffff 1 001
0 00 0 00000000 3ffff 0 000
1 01 2 00000000 00000 1 001
1 01 1 00000000 00000 1 001
1 01 0 00000100 00000 1 001
0 00 0 00000000 00000 0 100
1 02 0 00000002 00000 1 001
1 02 1 00000000 00000 1 001
1 02 2 00000000 00000 1 001
0 00 0 00000000 00000 0 100
1 01 1 00000200 00000 1 001
0 00 0 00000000 00000 0 002
0 00 0 00000000 00001 0 100
0 00 0 00000000 3ffff 0 000
1 1e 2 07f80000 3ffff 1 001
0 00 0 00000000 3ffff 0 1fe
0 00 0 00000000 3fdff 0 000
0 00 0 00000000 19033 0 0a7
0 00 0 00000000 02020 0 033
0 00 0 00000000 02021 0 199
0 00 0 00000000 02220 0 001
1 05 0 000000a8 19033 1 001

/* tb.f */
source/sprite_layout_pkg.sv
source/sprite_table_pkg.sv
source/sprite_regfile.sv
source/sprite_match.sv
source/sprite_table.sv
sim/sprite_checker.sv
sim/tb_sprite_table.sv

/* run_sim.sh */
#!/bin/sh
# compile the sprite table testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_sprite_table -f tb.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_sprite_table > sim.log 2>&1 || echo "simulator exited with an error"

cat sim.log

grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1

/* sim/tb_sprite_table.sv */
module tb_sprite_table;

	import sprite_layout_pkg::*;
	import sprite_table_pkg::*;

	localparam int    max_vectors  = 256;
	localparam int    reset_cycles = 5;
	localparam string vector_file  = "sim/sprite_table_input.txt";

	logic              clk = 1'b0;
	logic              arst_n;
	logic              written;
	idx_t              n_reg;
	fsel_t             select_field;
	logic [data_w-1:0] data;
	logic [key_w-1:0]  check;
	coord_t            read_data;
	logic              success;

	// expected values handed to the checker
	logic   vec_active;
	int     vec_num;
	logic   exp_success;
	coord_t exp_read;
	int     read_errors;
	int     success_errors;

	////////////////////
	// vector table
	////////////////////

	logic              vec_written [max_vectors];
	idx_t              vec_idx     [max_vectors];
	fsel_t             vec_sel     [max_vectors];
	logic [data_w-1:0] vec_data    [max_vectors];
	logic [key_w-1:0]  vec_key     [max_vectors];
	logic              vec_succ    [max_vectors];  // success one cycle later
	coord_t            vec_read    [max_vectors];  // read_data this cycle
	int                num_vectors = 0;

	int seed        = 34;
	int cycle_count = 0;
	int cycle_limit = 0;  // armed once the vectors are loaded
	bit loaded;

	always #2 clk = ~clk;

	sprite_table DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.written      (written),
		.n_reg        (n_reg),
		.select_field (select_field),
		.data         (data),
		.check        (check),
		.read_data    (read_data),
		.success      (success)
	);

	sprite_checker u_checker (
		.clk            (clk),
		.arst_n         (arst_n),
		.written        (written),
		.read_data      (read_data),
		.success        (success),
		.vec_active     (vec_active),
		.vec_num        (vec_num),
		.exp_success    (exp_success),
		.exp_read       (exp_read),
		.read_errors    (read_errors),
		.success_errors (success_errors)
	);

	////////////////////
	// watchdog
	////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic load_vectors(output bit ok);
		int               fd;
		int               code;
		logic [31:0]      f_w;
		logic [31:0]      f_idx;
		logic [31:0]      f_sel;
		logic [31:0]      f_data;
		logic [31:0]      f_key;
		logic [31:0]      f_succ;
		logic [31:0]      f_read;
		logic [8*200-1:0] skipped;

		ok = 1'b0;
		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			$display("cannot open the vector file %s", vector_file);
		end else begin
			while (!$feof(fd) && num_vectors < max_vectors) begin
				code = $fscanf(fd, " %h %h %h %h %h %h %h",
					f_w, f_idx, f_sel, f_data, f_key, f_succ, f_read);
				if (code == 7) begin
					vec_written[num_vectors] = f_w[0];
					vec_idx[num_vectors]     = f_idx[idx_w-1:0];
					vec_sel[num_vectors]     = f_sel[1:0];
					vec_data[num_vectors]    = f_data;
					vec_key[num_vectors]     = f_key[key_w-1:0];
					vec_succ[num_vectors]    = f_succ[0];
					vec_read[num_vectors]    = f_read[field_w-1:0];
					num_vectors++;
				end else begin
					code = $fgets(skipped, fd);  // comment line or blank tail
				end
			end
			$fclose(fd);
			if (num_vectors == 0)
				$display("the vector file %s holds no vectors", vector_file);
			else
				ok = 1'b1;
		end
	endtask

	task automatic drive_idle();
		written      = 1'b0;
		n_reg        = '0;
		select_field = '0;
		data         = '0;
		check        = '0;
		vec_active   = 1'b0;
		vec_num      = 0;
		exp_success  = 1'b0;
		exp_read     = not_found;
	endtask

	task automatic apply_vector(input int k);
		int rnd;

		rnd          = $random(seed);
		written      = vec_written[k];
		n_reg        = vec_idx[k];
		select_field = vec_sel[k];
		data         = {rnd[4:0], vec_data[k][26:0]};  // top bits are don't care
		check        = vec_key[k];
		exp_success  = vec_succ[k];
		exp_read     = vec_read[k];
		vec_num      = k;
		vec_active   = 1'b1;
	endtask

	initial begin
		arst_n = 1'b0;
		drive_idle();
		load_vectors(loaded);
		if (!loaded) begin
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			cycle_limit = num_vectors + reset_cycles + 20;
			repeat (reset_cycles) @(posedge clk);
			#1;
			arst_n = 1'b1;
			for (int k = 0; k < num_vectors; k++) begin
				@(posedge clk);
				#1;
				apply_vector(k);
			end
			@(posedge clk);
			#1;
			drive_idle();  // last success pulse is checked in this cycle
			repeat (3) @(posedge clk);
			$display("errors: read_data %0d, success %0d", read_errors, success_errors);
			if (read_errors + success_errors == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

/* sim/sprite_checker.sv */
module sprite_checker (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      written,
	input  sprite_layout_pkg::coord_t read_data,
	input  logic                      success,
	input  logic                      vec_active,   // a vector is on the inputs
	input  int                        vec_num,
	input  logic                      exp_success,  // due one cycle later
	input  sprite_layout_pkg::coord_t exp_read,
	output int                        read_errors,
	output int                        success_errors
);

	import sprite_layout_pkg::*;
	import sprite_table_pkg::*;

	int   rd_err       = 0;
	int   succ_err     = 0;
	logic prev_active  = 1'b0;
	logic prev_success = 1'b0;
	int   prev_num     = 0;
	logic want_success;

	assign read_errors    = rd_err;
	assign success_errors = succ_err;

	////////////////////
	// compare
	////////////////////

	// mid-cycle sampling, inputs move one unit after the rising edge
	always @(negedge clk) begin
		if (!arst_n) begin
			if (read_data !== not_found) begin
				$display("Error at %0t: read_data %h during reset, expected %h",
					$time, read_data, not_found);
				rd_err++;
			end
			if (success !== 1'b0) begin
				$display("Error at %0t: success high during reset", $time);
				succ_err++;
			end
			prev_active = 1'b0;
		end else begin
			// the pulse answers the vector of the previous cycle
			want_success = prev_active ? prev_success : 1'b0;
			if (success !== want_success) begin
				if (prev_active)
					$display("Error at %0t: success %b after vector %0d, expected %b",
						$time, success, prev_num, want_success);
				else
					$display("Error at %0t: success %b with no write pending",
						$time, success);
				succ_err++;
			end

			if (vec_active && read_data !== exp_read) begin
				$display("Error at %0t: read_data %h for vector %0d, expected %h",
					$time, read_data, vec_num, exp_read);
				rd_err++;
			end

			// lookup is blocked whenever a write is presented
			if (written && read_data !== not_found) begin
				$display("Error at %0t: read_data %h while written is high", $time, read_data);
				rd_err++;
			end

			prev_active  = vec_active;
			prev_success = exp_success;
			prev_num     = vec_num;
		end
	end

endmodule

/* source/sprite_table.sv */
module sprite_table (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 written,
	input  sprite_table_pkg::idx_t               n_reg,
	input  sprite_layout_pkg::fsel_t             select_field,
	input  logic [sprite_layout_pkg::data_w-1:0] data,
	input  logic [sprite_layout_pkg::key_w-1:0]  check,
	output sprite_layout_pkg::coord_t            read_data,
	output logic                                 success
);

	import sprite_layout_pkg::*;
	import sprite_table_pkg::*;

	logic [num_entries-1:0]   entry_valid;
	coord_t [num_entries-1:0] entry_offset;
	coord_t [num_entries-1:0] entry_x;
	coord_t [num_entries-1:0] entry_y;

	////////////////////
	// storage
	////////////////////

	sprite_regfile u_regfile (
		.clk          (clk),
		.arst_n       (arst_n),
		.written      (written),
		.n_reg        (n_reg),
		.select_field (select_field),
		.data         (data),
		.success      (success),
		.entry_valid  (entry_valid),
		.entry_offset (entry_offset),
		.entry_x      (entry_x),
		.entry_y      (entry_y)
	);

	////////////////////
	// lookup
	////////////////////

	sprite_match u_match (
		.written      (written),      // blocks the result during writes
		.check        (check),
		.entry_valid  (entry_valid),
		.entry_offset (entry_offset),
		.entry_x      (entry_x),
		.entry_y      (entry_y),
		.read_data    (read_data)
	);

endmodule

/* source/sprite_match.sv */
module sprite_match (
	input  logic                                                          written,
	input  logic [sprite_layout_pkg::key_w-1:0]                           check,
	input  logic [sprite_table_pkg::num_entries-1:0]                      entry_valid,
	input  sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_offset,
	input  sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_x,
	input  sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_y,
	output sprite_layout_pkg::coord_t                                     read_data
);

	import sprite_layout_pkg::*;
	import sprite_table_pkg::*;

	coord_t                 key_x;
	coord_t                 key_y;
	logic [num_entries-1:0] hit;      // per slot compare result
	logic                   any_hit;
	idx_t                   hit_idx;  // lowest matching slot

	////////////////////
	// parallel compare
	////////////////////

	// key layout is {x, y}, same order as the data word
	assign key_x = check[field_w +: field_w];
	assign key_y = check[0 +: field_w];

	for (genvar i = 0; i < num_entries; i++) begin : g_cmp
		assign hit[i] = entry_valid[i] &&
			(entry_x[i] == key_x) &&
			(entry_y[i] == key_y);
	end

	assign any_hit = |hit;

	////////////////////
	// priority scan
	////////////////////

	// walk downwards so the lowest index is written last and wins
	always_comb begin
		hit_idx = reserved_idx;
		for (int i = num_entries - 1; i >= 0; i--) begin
			if (hit[i])
				hit_idx = idx_t'(i);
		end
	end

	always_comb begin
		if (written || !any_hit)
			read_data = not_found;            // busy or no sprite here
		else
			read_data = entry_offset[hit_idx];
	end

endmodule

/* source/sprite_regfile.sv */
module sprite_regfile (
	input  logic                                                          clk,
	input  logic                                                          arst_n,
	input  logic                                                          written,
	input  sprite_table_pkg::idx_t                                        n_reg,
	input  sprite_layout_pkg::fsel_t                                      select_field,
	input  logic [sprite_layout_pkg::data_w-1:0]                          data,
	output logic                                                          success,
	output logic [sprite_table_pkg::num_entries-1:0]                      entry_valid,
	output sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_offset,
	output sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_x,
	output sprite_layout_pkg::coord_t [sprite_table_pkg::num_entries-1:0] entry_y
);

	import sprite_layout_pkg::*;
	import sprite_table_pkg::*;

	logic                   field_ok;  // select code names a real field
	logic                   idx_ok;    // not the reserved slot
	logic                   accept;
	logic [num_entries-1:0] wr_en;     // one-hot slot enable
	coord_t                 offset_in;
	coord_t                 y_in;
	coord_t                 x_in;

	////////////////////
	// write decode
	////////////////////

	// each field has its own fixed slice of the data word
	assign offset_in = data[offset_lsb +: field_w];
	assign y_in      = data[y_lsb +: field_w];
	assign x_in      = data[x_lsb +: field_w];

	assign field_ok = (select_field == fsel_offset) ||
		(select_field == fsel_y) ||
		(select_field == fsel_x);

	assign idx_ok = (n_reg != reserved_idx);

	assign accept = written && idx_ok && field_ok;

	////////////////////
	// entry storage
	////////////////////

	for (genvar i = 0; i < num_entries; i++) begin : g_entry

		assign wr_en[i] = accept && (n_reg == idx_t'(i));

		// only the selected field moves, the other two hold
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				entry_offset[i] <= '0;
				entry_y[i]      <= '0;
				entry_x[i]      <= '0;
			end else if (wr_en[i]) begin
				case (select_field)
					fsel_offset: entry_offset[i] <= offset_in;
					fsel_y:      entry_y[i]      <= y_in;
					default:     entry_x[i]      <= x_in; // fsel_x only, wr_en needs field_ok
				endcase
			end
		end

	end

	////////////////////
	// valid and status
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			entry_valid <= '0;
			success     <= 1'b0;
		end else begin
			success     <= accept;               // one pulse per accepted write
			entry_valid <= entry_valid | wr_en;  // any field write arms the slot
		end
	end

	// a pulse always traces back to a legal write one edge earlier
	a_success_has_cause: assert property (
		@(posedge clk) disable iff (!arst_n)
		success |-> $past(written && n_reg != reserved_idx)
	);

	// the reserved slot must never take part in a lookup
	a_reserved_never_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		!entry_valid[reserved_idx]
	);

endmodule

/* source/sprite_table_pkg.sv */
package sprite_table_pkg;

	////////////////////
	// table geometry
	////////////////////

	localparam int idx_w = 5;

	localparam int num_entries = 1 << idx_w; // slot 0 included

	typedef logic [idx_w-1:0] idx_t;

	// slot 0 is never written, so usable sprites are 1 to 31
	localparam idx_t reserved_idx = '0;

	////////////////////
	// lookup result
	////////////////////

	// returned when no valid entry holds the key, or while a write is presented
	localparam sprite_layout_pkg::coord_t not_found = 9'd1;

endpackage

/* source/sprite_layout_pkg.sv */
package sprite_layout_pkg;

	////////////////////
	// sprite fields
	////////////////////

	localparam int field_w = 9; // offset, y and x are all this wide

	typedef logic [field_w-1:0] coord_t; // coordinate or pattern offset

	localparam int key_w = 2 * field_w; // search key is {x, y}

	////////////////////
	// write data word
	////////////////////

	localparam int data_w = 32;

	// low bit of each field inside the data word
	localparam int offset_lsb = 0;
	localparam int y_lsb      = 9;
	localparam int x_lsb      = 18; // bits 27 to 31 carry nothing

	////////////////////
	// field select
	////////////////////

	typedef logic [1:0] fsel_t;

	localparam fsel_t fsel_offset = 2'd0;
	localparam fsel_t fsel_y      = 2'd1;
	localparam fsel_t fsel_x      = 2'd2; // code 3 is rejected

endpackage
